//--- hw/bridge_config_regs.sv
/*
  option registers written from the host bridge, write only.
  fields take the low bits of the write word, upper bits are dropped.
  reset, mapper and system type writes start a core reset hold.
*/

`timescale 1ns/1ns
`default_nettype none

module bridge_config_regs #(
  parameter int RESET_HOLD_CYCLES = 1048576
) (
  input  wire                       clk_sys,
  input  wire                       pll_core_locked,
  input  wire                       bridge_wr,
  input  wire gb_glue_pkg::bridge_addr_t bridge_addr,
  input  wire gb_glue_pkg::bridge_data_t bridge_wr_data,
  output logic [2:0]                mapper_sel,
  output logic [1:0]                sys_type,
  output logic [1:0]                tint,
  output logic [1:0]                sgb_en,
  output logic                      rumble_en,
  output logic                      ff_snd_en,
  output logic                      sgc_gbc_en,
  output logic                      rw_en,
  output logic                      reset_hold
);
  import gb_glue_pkg::*;

  localparam int CNT_W = $clog2(RESET_HOLD_CYCLES + 1);

  logic [CNT_W-1:0] hold_cnt;
  logic             reset_req;

  // writes that need the core restarted
  assign reset_req = bridge_wr && (bridge_addr == REG_RESET_ADDR ||
                                   bridge_addr == REG_MAPPER_ADDR ||
                                   bridge_addr == REG_SYSTYPE_ADDR);

  always_ff @(posedge clk_sys or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      mapper_sel <= '0;
      sys_type   <= '0;
      tint       <= '0;
      sgb_en     <= '0;
      rumble_en  <= 1'b0;
      ff_snd_en  <= 1'b0;
      sgc_gbc_en <= 1'b0;
      rw_en      <= 1'b0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        REG_MAPPER_ADDR:  mapper_sel <= bridge_wr_data[2:0];
        REG_RUMBLE_ADDR:  rumble_en  <= bridge_wr_data[0];
        REG_SYSTYPE_ADDR: sys_type   <= bridge_wr_data[1:0];
        REG_FFSND_ADDR:   ff_snd_en  <= bridge_wr_data[0];
        REG_TINT_ADDR:    tint       <= bridge_wr_data[1:0];
        REG_SGB_ADDR:     sgb_en     <= bridge_wr_data[1:0];
        REG_SGBGBC_ADDR:  sgc_gbc_en <= bridge_wr_data[0];
        REG_REWIND_ADDR:  rw_en      <= bridge_wr_data[0];
        default: ;
      endcase
    end
  end

  // hold countdown, a new request restarts it
  always_ff @(posedge clk_sys or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_cnt <= '0;
    end else if (reset_req) begin
      hold_cnt <= CNT_W'(RESET_HOLD_CYCLES);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  assign reset_hold = (hold_cnt != '0);

endmodule

`default_nettype wire

//--- hw/download_ctrl.sv
/*
  tracks one download at a time from request to all-complete.
  class outputs are only valid while the download is active.
*/

`timescale 1ns/1ns
`default_nettype none

module download_ctrl (
  input  wire                   clk_sys,
  input  wire                   pll_core_locked,
  input  wire                   slot_request_write,
  input  wire gb_glue_pkg::slot_id_t slot_id,
  input  wire                   slot_all_complete,
  input  wire                   reset_hold,
  output logic                  download_active,
  output logic                  cart_download,
  output logic                  palette_download,
  output logic                  border_download,
  output logic                  boot_download,
  output logic                  core_reset
);
  import gb_glue_pkg::*;

  slot_id_t cur_id;
  logic     is_cart;
  logic     is_boot;

  // request wins over a completion in the same cycle
  always_ff @(posedge clk_sys or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      download_active <= 1'b0;
    end else if (slot_request_write) begin
      download_active <= 1'b1;
    end else if (slot_all_complete) begin
      download_active <= 1'b0;
    end
  end

  always_ff @(posedge clk_sys) begin
    if (slot_request_write) begin
      cur_id <= slot_id;
    end
  end

  // cartridge ids are x01 in the low six bits, or 0x80
  assign is_cart = (cur_id[5:0] == 6'h01) || (cur_id[7:0] == 8'h80);
  assign is_boot = (cur_id == SLOT_BOOT_CGB) || (cur_id == SLOT_BOOT_DMG) ||
                   (cur_id == SLOT_BOOT_SGB);

  assign cart_download    = download_active && is_cart;
  assign palette_download = download_active && (cur_id == SLOT_PALETTE);
  assign border_download  = download_active && (cur_id == SLOT_BORDER);
  assign boot_download    = download_active && is_boot;

  assign core_reset = reset_hold || cart_download || boot_download;

endmodule

`default_nettype wire

//--- hw/fast_forward_ctrl.sv
/*
  fast-forward button, held or tapped to latch.
  a second tap right after a latching tap does not latch again.
  press length saturates at TAP_MAX_CYCLES.
*/

`timescale 1ns/1ns
`default_nettype none

module fast_forward_ctrl #(
  parameter int TAP_MAX_CYCLES = 3200000
) (
  input  wire                        clk_sys,
  input  wire                        pll_core_locked,
  input  wire                        ff_button,
  input  wire                        download_active,
  input  wire                        ff_snd_en,
  input  wire gb_glue_pkg::audio_sample_t audio_in_l,
  input  wire gb_glue_pkg::audio_sample_t audio_in_r,
  output logic                       fast_forward,
  output gb_glue_pkg::audio_sample_t audio_out_l,
  output gb_glue_pkg::audio_sample_t audio_out_r
);
  localparam int CNT_W = $clog2(TAP_MAX_CYCLES + 1);

  logic             ff_req;
  logic             req_prev;
  logic             ff_latch;
  logic             ff_was_held;
  logic [CNT_W-1:0] ff_count;
  logic             audio_mute;

  // button is ignored while loading
  assign ff_req = ff_button && !download_active;

  ////////////////////////////////////////////////////////////////////////////
  // tap / hold latch
  always_ff @(posedge clk_sys or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      req_prev     <= 1'b0;
      ff_latch     <= 1'b0;
      ff_was_held  <= 1'b0;
      ff_count     <= '0;
      fast_forward <= 1'b0;
    end else begin
      req_prev <= ff_req;
      if (ff_req && ff_count != CNT_W'(TAP_MAX_CYCLES)) begin
        ff_count <= ff_count + 1'b1;
      end
      // press, the first held cycle counts
      if (ff_req && !req_prev) begin
        ff_latch <= 1'b0;
        ff_count <= CNT_W'(1);
      end
      // release, short press latches unless the last one did
      if (!ff_req && req_prev) begin
        ff_was_held <= 1'b0;
        if (ff_count < CNT_W'(TAP_MAX_CYCLES) && !ff_was_held) begin
          ff_was_held <= 1'b1;
          ff_latch    <= 1'b1;
        end
      end
      fast_forward <= ff_req || ff_latch;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // audio register with mute
  assign audio_mute = fast_forward && !ff_snd_en;

  always_ff @(posedge clk_sys or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      audio_out_l <= '0;
      audio_out_r <= '0;
    end else begin
      audio_out_l <= audio_mute ? '0 : audio_in_l;
      audio_out_r <= audio_mute ? '0 : audio_in_r;
    end
  end

endmodule

`default_nettype wire

//--- hw/gb_core_glue.sv
/*
  glue logic around the emulator core, all in the clk_sys domain.
  bridge and download inputs must already be synchronous to clk_sys.
  RESET_HOLD_CYCLES and TAP_MAX_CYCLES scale with the clk_sys rate.
*/

`timescale 1ns/1ns
`default_nettype none

module gb_core_glue #(
  parameter int RESET_HOLD_CYCLES = 1048576,
  parameter int TAP_MAX_CYCLES    = 3200000
) (
  input  wire                        clk_sys,
  input  wire                        pll_core_locked,
  // host bridge
  input  wire                        bridge_wr,
  input  wire gb_glue_pkg::bridge_addr_t bridge_addr,
  input  wire gb_glue_pkg::bridge_data_t bridge_wr_data,
  // downloads
  input  wire                        slot_request_write,
  input  wire gb_glue_pkg::slot_id_t slot_id,
  input  wire                        slot_all_complete,
  input  wire                        ioctl_wr,
  input  wire gb_glue_pkg::ioctl_word_t ioctl_data,
  // controls, audio and lcd from the core
  input  wire                        ff_button,
  input  wire gb_glue_pkg::audio_sample_t audio_in_l,
  input  wire gb_glue_pkg::audio_sample_t audio_in_r,
  input  wire                        lcd_hblank,
  input  wire                        lcd_vblank,
  input  wire                        lcd_hs,
  input  wire                        lcd_vs,
  input  wire gb_glue_pkg::rgb_t     lcd_rgb,
  input  wire                        bw_en,
  // core options
  output wire [2:0]                  mapper_sel,
  output wire [1:0]                  sys_type,
  output wire [1:0]                  tint,
  output wire [1:0]                  sgb_en,
  output wire                        rumble_en,
  output wire                        sgc_gbc_en,
  output wire                        rw_en,
  // download classes
  output wire                        core_reset,
  output wire                        cart_download,
  output wire                        border_download,
  output wire                        boot_download,
  output wire gb_glue_pkg::rgb_t     pal1,
  output wire gb_glue_pkg::rgb_t     pal2,
  output wire gb_glue_pkg::rgb_t     pal3,
  output wire gb_glue_pkg::rgb_t     pal4,
  // speed and audio
  output wire                        fast_forward,
  output wire gb_glue_pkg::audio_sample_t audio_out_l,
  output wire gb_glue_pkg::audio_sample_t audio_out_r,
  // video to the scaler
  output wire                        video_de,
  output wire                        video_hs,
  output wire                        video_vs,
  output wire gb_glue_pkg::rgb_t     video_rgb
);

  wire reset_hold;
  wire ff_snd_en;
  wire download_active;
  wire palette_download;

  bridge_config_regs #(
    .RESET_HOLD_CYCLES (RESET_HOLD_CYCLES)
  ) cfg0 (
    .clk_sys         (clk_sys),
    .pll_core_locked (pll_core_locked),
    .bridge_wr       (bridge_wr),
    .bridge_addr     (bridge_addr),
    .bridge_wr_data  (bridge_wr_data),
    .mapper_sel      (mapper_sel),
    .sys_type        (sys_type),
    .tint            (tint),
    .sgb_en          (sgb_en),
    .rumble_en       (rumble_en),
    .ff_snd_en       (ff_snd_en),
    .sgc_gbc_en      (sgc_gbc_en),
    .rw_en           (rw_en),
    .reset_hold      (reset_hold)
  );

  download_ctrl dl0 (
    .clk_sys            (clk_sys),
    .pll_core_locked    (pll_core_locked),
    .slot_request_write (slot_request_write),
    .slot_id            (slot_id),
    .slot_all_complete  (slot_all_complete),
    .reset_hold         (reset_hold),
    .download_active    (download_active),
    .cart_download      (cart_download),
    .palette_download   (palette_download),
    .border_download    (border_download),
    .boot_download      (boot_download),
    .core_reset         (core_reset)
  );

  palette_store pal0 (
    .clk_sys          (clk_sys),
    .pll_core_locked  (pll_core_locked),
    .palette_download (palette_download),
    .ioctl_wr         (ioctl_wr),
    .ioctl_data       (ioctl_data),
    .pal1             (pal1),
    .pal2             (pal2),
    .pal3             (pal3),
    .pal4             (pal4)
  );

  fast_forward_ctrl #(
    .TAP_MAX_CYCLES (TAP_MAX_CYCLES)
  ) ff0 (
    .clk_sys         (clk_sys),
    .pll_core_locked (pll_core_locked),
    .ff_button       (ff_button),
    .download_active (download_active),
    .ff_snd_en       (ff_snd_en),
    .audio_in_l      (audio_in_l),
    .audio_in_r      (audio_in_r),
    .fast_forward    (fast_forward),
    .audio_out_l     (audio_out_l),
    .audio_out_r     (audio_out_r)
  );

  video_out_cond vid0 (
    .clk_sys         (clk_sys),
    .pll_core_locked (pll_core_locked),
    .lcd_hblank      (lcd_hblank),
    .lcd_vblank      (lcd_vblank),
    .lcd_hs          (lcd_hs),
    .lcd_vs          (lcd_vs),
    .lcd_rgb         (lcd_rgb),
    .bw_en           (bw_en),
    .video_de        (video_de),
    .video_hs        (video_hs),
    .video_vs        (video_vs),
    .video_rgb       (video_rgb)
  );

endmodule

`default_nettype wire

//--- hw/gb_glue_pkg.sv
/*
  shared types and constants for the emulator glue logic.
  register addresses are byte addresses on the host bridge bus.
  slot ids follow the data slot numbering of the host loader.
*/

`default_nettype none

package gb_glue_pkg;

  // host bridge
  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  // download path
  typedef logic [15:0] slot_id_t;
  typedef logic [15:0] ioctl_word_t;

  // audio and video
  typedef logic signed [15:0] audio_sample_t;
  typedef logic [23:0]        rgb_t;
  typedef logic [7:0]         channel_t;

  ////////////////////////////////////////////////////////////////////////////
  // option register map
  localparam bridge_addr_t REG_RESET_ADDR   = 32'h0000_0050;
  localparam bridge_addr_t REG_MAPPER_ADDR  = 32'h0000_0200;
  localparam bridge_addr_t REG_RUMBLE_ADDR  = 32'h0000_0204;
  localparam bridge_addr_t REG_SYSTYPE_ADDR = 32'h0000_0208;
  localparam bridge_addr_t REG_FFSND_ADDR   = 32'h0000_020C;
  localparam bridge_addr_t REG_TINT_ADDR    = 32'h0000_0210;
  localparam bridge_addr_t REG_SGB_ADDR     = 32'h0000_0214;
  localparam bridge_addr_t REG_SGBGBC_ADDR  = 32'h0000_0218;
  localparam bridge_addr_t REG_REWIND_ADDR  = 32'h0000_021C;

  ////////////////////////////////////////////////////////////////////////////
  // slot ids, cartridge ids are decoded by pattern instead
  localparam slot_id_t SLOT_BORDER   = 16'd2;
  localparam slot_id_t SLOT_PALETTE  = 16'd3;
  localparam slot_id_t SLOT_BOOT_CGB = 16'd4;
  localparam slot_id_t SLOT_BOOT_DMG = 16'd5;
  localparam slot_id_t SLOT_BOOT_SGB = 16'd6;

  // four shades in the top 96 bits, low word unused
  localparam logic [127:0] DEFAULT_PALETTE = 128'h8282_1451_7356_305A_5F1A_3B49_0000_0000;

  // keeps the output hsync pulse clear of vsync
  localparam int HS_DELAY = 7;

endpackage

`default_nettype wire

//--- hw/palette_store.sv
/*
  palette loaded as a stream of 16-bit words, bytes swapped on entry.
  only the top 96 bits are shown as shades, the last word is dropped.
*/

`timescale 1ns/1ns
`default_nettype none

module palette_store (
  input  wire                      clk_sys,
  input  wire                      pll_core_locked,
  input  wire                      palette_download,
  input  wire                      ioctl_wr,
  input  wire gb_glue_pkg::ioctl_word_t ioctl_data,
  output gb_glue_pkg::rgb_t        pal1,
  output gb_glue_pkg::rgb_t        pal2,
  output gb_glue_pkg::rgb_t        pal3,
  output gb_glue_pkg::rgb_t        pal4
);
  import gb_glue_pkg::*;

  logic [127:0] palette;

  // shift in at the bottom, oldest word ends up in pal1
  always_ff @(posedge clk_sys or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      palette <= DEFAULT_PALETTE;
    end else if (palette_download && ioctl_wr) begin
      palette <= {palette[111:0], ioctl_data[7:0], ioctl_data[15:8]};
    end
  end

  assign pal1 = palette[127:104];
  assign pal2 = palette[103:80];
  assign pal3 = palette[79:56];
  assign pal4 = palette[55:32];

endmodule

`default_nettype wire

//--- hw/video_out_cond.sv
/*
  video output stage for the scaler, one register stage deep.
  hsync out is a single pulse HS_DELAY cycles after the input rise,
  a new rise inside that window restarts the delay.
  grayscale is an approximate luminance, overflow wraps.
*/

`timescale 1ns/1ns
`default_nettype none

module video_out_cond (
  input  wire                clk_sys,
  input  wire                pll_core_locked,
  input  wire                lcd_hblank,
  input  wire                lcd_vblank,
  input  wire                lcd_hs,
  input  wire                lcd_vs,
  input  wire gb_glue_pkg::rgb_t lcd_rgb,
  input  wire                bw_en,
  output logic               video_de,
  output logic               video_hs,
  output logic               video_vs,
  output gb_glue_pkg::rgb_t  video_rgb
);
  import gb_glue_pkg::*;

  localparam int DLY_W = $clog2(HS_DELAY + 1);

  logic             active_area;
  logic             hs_prev;
  logic             vs_prev;
  logic [DLY_W-1:0] hs_delay;
  rgb_t             rgb_reg;
  channel_t         red;
  channel_t         grn;
  channel_t         blu;
  channel_t         lum;

  assign active_area = !(lcd_hblank || lcd_vblank);

  ////////////////////////////////////////////////////////////////////////////
  // registered de, colour and sync pulses
  always_ff @(posedge clk_sys or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_de <= 1'b0;
      video_hs <= 1'b0;
      video_vs <= 1'b0;
      rgb_reg  <= '0;
      hs_prev  <= 1'b0;
      vs_prev  <= 1'b0;
      hs_delay <= '0;
    end else begin
      video_de <= active_area;
      rgb_reg  <= active_area ? lcd_rgb : '0;
      hs_prev  <= lcd_hs;
      vs_prev  <= lcd_vs;
      // vsync is shortened to one cycle
      video_vs <= lcd_vs && !vs_prev;
      video_hs <= (hs_delay == DLY_W'(1));
      if (lcd_hs && !hs_prev) begin
        hs_delay <= DLY_W'(HS_DELAY);
      end else if (hs_delay != '0) begin
        hs_delay <= hs_delay - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // grayscale, roughly 0.28r + 0.56g + 0.09b
  assign red = rgb_reg[23:16];
  assign grn = rgb_reg[15:8];
  assign blu = rgb_reg[7:0];

  assign lum = (red >> 2) + (red >> 5) + (grn >> 1) + (grn >> 4) +
               (blu >> 4) + (blu >> 5);

  assign video_rgb = bw_en ? {lum, lum, lum} : rgb_reg;

endmodule

`default_nettype wire

//--- project.f
hw/gb_glue_pkg.sv
hw/bridge_config_regs.sv
hw/download_ctrl.sv
hw/palette_store.sv
hw/fast_forward_ctrl.sv
hw/video_out_cond.sv
hw/gb_core_glue.sv
test/glue_checker.sv
test/tb_gb_core_glue.sv

//--- run_sim.sh
#!/bin/sh
# build and run the glue testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
  -f project.f \
  --top-module tb_gb_core_glue \
  --Mdir obj_dir \
  -o sim_glue

./obj_dir/sim_glue > sim.log
cat sim.log

if grep -q '^>>> PASS$' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- test/glue_checker.sv
/*
  watches the glue top level and compares every output on the falling edge.
  the reference state is updated on the same rising edges as the DUT.
  checks are held off while pll_core_locked is low.
*/

`timescale 1ns/1ns
`default_nettype none

module glue_checker #(
  parameter int RESET_HOLD_CYCLES = 16,
  parameter int TAP_MAX_CYCLES    = 20
) (
  input  wire        clk_sys,
  input  wire        pll_core_locked,
  input  wire        bridge_wr,
  input  wire [31:0] bridge_addr,
  input  wire [31:0] bridge_wr_data,
  input  wire        slot_request_write,
  input  wire [15:0] slot_id,
  input  wire        slot_all_complete,
  input  wire        ioctl_wr,
  input  wire [15:0] ioctl_data,
  input  wire        ff_button,
  input  wire [15:0] audio_in_l,
  input  wire [15:0] audio_in_r,
  input  wire        lcd_hblank,
  input  wire        lcd_vblank,
  input  wire        lcd_hs,
  input  wire        lcd_vs,
  input  wire [23:0] lcd_rgb,
  input  wire        bw_en,
  input  wire [2:0]  mapper_sel,
  input  wire [1:0]  sys_type,
  input  wire [1:0]  tint,
  input  wire [1:0]  sgb_en,
  input  wire        rumble_en,
  input  wire        sgc_gbc_en,
  input  wire        rw_en,
  input  wire        core_reset,
  input  wire        cart_download,
  input  wire        border_download,
  input  wire        boot_download,
  input  wire [23:0] pal1,
  input  wire [23:0] pal2,
  input  wire [23:0] pal3,
  input  wire [23:0] pal4,
  input  wire        fast_forward,
  input  wire [15:0] audio_out_l,
  input  wire [15:0] audio_out_r,
  input  wire        video_de,
  input  wire        video_hs,
  input  wire        video_vs,
  input  wire [23:0] video_rgb,
  output logic [31:0] error_count
);
  import gb_glue_pkg::*;

  int           errors = 0;
  logic [2:0]   m_mapper;
  logic [1:0]   m_sys;
  logic [1:0]   m_tint;
  logic [1:0]   m_sgb;
  logic         m_rumble;
  logic         m_ffsnd;
  logic         m_sgbgbc;
  logic         m_rw;
  int           m_hold;
  logic         m_active;
  logic [15:0]  m_id;
  logic [127:0] m_pal;
  logic         m_req_prev;
  logic         m_latch;
  logic         m_was;
  int           m_held;
  logic         m_ff;
  logic [15:0]  m_aud_l;
  logic [15:0]  m_aud_r;
  logic         m_de;
  logic [23:0]  m_rgb;
  logic         m_vs;
  logic         m_vs_prev;
  logic         m_hs;
  logic         m_hs_prev;
  logic [6:0]   m_rise_hist;
  logic         m_req;
  logic         m_hs_rise;
  logic         m_area;
  logic [7:0]   m_lum;

  assign error_count = errors;
  assign m_req       = ff_button && !m_active;
  assign m_hs_rise   = lcd_hs && !m_hs_prev;
  assign m_area      = !lcd_hblank && !lcd_vblank;
  assign m_lum       = luminance(m_rgb);

  ////////////////////////////////////////////////////////////////////////////
  // reference functions

  function automatic logic [7:0] luminance(input logic [23:0] c);
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    r = c[23:16];
    g = c[15:8];
    b = c[7:0];
    return 8'(r / 4 + r / 32 + g / 2 + g / 16 + b / 16 + b / 32);
  endfunction

  function automatic logic cart_id(input logic [15:0] id);
    return (id[5:0] == 6'd1) || (id[7:0] == 8'h80);
  endfunction

  function automatic logic boot_id(input logic [15:0] id);
    return id == 16'd4 || id == 16'd5 || id == 16'd6;
  endfunction

  function automatic logic restart_addr(input logic [31:0] a);
    return a == REG_RESET_ADDR || a == REG_MAPPER_ADDR || a == REG_SYSTYPE_ADDR;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reference state

  always @(posedge clk_sys or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      m_mapper <= '0;
      m_sys <= '0;
      m_tint <= '0;
      m_sgb <= '0;
      m_rumble <= 1'b0;
      m_ffsnd <= 1'b0;
      m_sgbgbc <= 1'b0;
      m_rw <= 1'b0;
      m_hold <= 0;
      m_active <= 1'b0;
      m_id <= '0;
      m_pal <= 128'h8282_1451_7356_305A_5F1A_3B49_0000_0000;
      m_req_prev <= 1'b0;
      m_latch <= 1'b0;
      m_was <= 1'b0;
      m_held <= 0;
      m_ff <= 1'b0;
      m_aud_l <= '0;
      m_aud_r <= '0;
      m_de <= 1'b0;
      m_rgb <= '0;
      m_vs <= 1'b0;
      m_vs_prev <= 1'b0;
      m_hs <= 1'b0;
      m_hs_prev <= 1'b0;
      m_rise_hist <= '0;
    end else begin
      if (bridge_wr) begin
        case (bridge_addr)
          REG_MAPPER_ADDR:  m_mapper <= bridge_wr_data[2:0];
          REG_SYSTYPE_ADDR: m_sys <= bridge_wr_data[1:0];
          REG_TINT_ADDR:    m_tint <= bridge_wr_data[1:0];
          REG_SGB_ADDR:     m_sgb <= bridge_wr_data[1:0];
          REG_RUMBLE_ADDR:  m_rumble <= bridge_wr_data[0];
          REG_FFSND_ADDR:   m_ffsnd <= bridge_wr_data[0];
          REG_SGBGBC_ADDR:  m_sgbgbc <= bridge_wr_data[0];
          REG_REWIND_ADDR:  m_rw <= bridge_wr_data[0];
          default: ;
        endcase
      end
      if (bridge_wr && restart_addr(bridge_addr)) begin
        m_hold <= RESET_HOLD_CYCLES;
      end else if (m_hold > 0) begin
        m_hold <= m_hold - 1;
      end
      if (slot_request_write) begin
        m_active <= 1'b1;
        m_id <= slot_id;
      end else if (slot_all_complete) begin
        m_active <= 1'b0;
      end
      // byte-swapped word enters at the bottom
      if (m_active && m_id == 16'd3 && ioctl_wr) begin
        m_pal <= {m_pal[111:0], ioctl_data[7:0], ioctl_data[15:8]};
      end
      // fast-forward, press length counted in sampled cycles
      m_ff <= m_req || m_latch;
      m_req_prev <= m_req;
      if (m_req && !m_req_prev) begin
        m_latch <= 1'b0;
        m_held <= 1;
      end else if (m_req && m_held < TAP_MAX_CYCLES) begin
        m_held <= m_held + 1;
      end
      if (!m_req && m_req_prev) begin
        if (m_held < TAP_MAX_CYCLES && !m_was) begin
          m_latch <= 1'b1;
          m_was <= 1'b1;
        end else begin
          m_was <= 1'b0;
        end
      end
      m_aud_l <= (m_ff && !m_ffsnd) ? 16'd0 : audio_in_l;
      m_aud_r <= (m_ff && !m_ffsnd) ? 16'd0 : audio_in_r;
      // video
      m_de <= m_area;
      m_rgb <= m_area ? lcd_rgb : 24'd0;
      m_vs_prev <= lcd_vs;
      m_vs <= lcd_vs && !m_vs_prev;
      m_hs_prev <= lcd_hs;
      m_rise_hist <= {m_rise_hist[5:0], m_hs_rise};
      // pulse only for a rise that no later rise has overtaken
      m_hs <= m_rise_hist[6] && (m_rise_hist[5:0] == 6'd0);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // comparison

  task automatic compare(input string name, input logic [31:0] got,
                         input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR @%0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  always @(negedge clk_sys) begin
    if (pll_core_locked) begin
      compare("mapper_sel", 32'(mapper_sel), 32'(m_mapper));
      compare("sys_type", 32'(sys_type), 32'(m_sys));
      compare("tint", 32'(tint), 32'(m_tint));
      compare("sgb_en", 32'(sgb_en), 32'(m_sgb));
      compare("rumble_en", 32'(rumble_en), 32'(m_rumble));
      compare("sgc_gbc_en", 32'(sgc_gbc_en), 32'(m_sgbgbc));
      compare("rw_en", 32'(rw_en), 32'(m_rw));
      compare("cart_download", 32'(cart_download), 32'(m_active && cart_id(m_id)));
      compare("border_download", 32'(border_download),
              32'(m_active && m_id == 16'd2));
      compare("boot_download", 32'(boot_download), 32'(m_active && boot_id(m_id)));
      compare("core_reset", 32'(core_reset),
              32'(m_hold > 0 || (m_active && (cart_id(m_id) || boot_id(m_id)))));
      compare("pal1", 32'(pal1), 32'(m_pal[127:104]));
      compare("pal2", 32'(pal2), 32'(m_pal[103:80]));
      compare("pal3", 32'(pal3), 32'(m_pal[79:56]));
      compare("pal4", 32'(pal4), 32'(m_pal[55:32]));
      compare("fast_forward", 32'(fast_forward), 32'(m_ff));
      compare("audio_out_l", 32'(audio_out_l), 32'(m_aud_l));
      compare("audio_out_r", 32'(audio_out_r), 32'(m_aud_r));
      compare("video_de", 32'(video_de), 32'(m_de));
      compare("video_hs", 32'(video_hs), 32'(m_hs));
      compare("video_vs", 32'(video_vs), 32'(m_vs));
      compare("video_rgb", 32'(video_rgb), 32'(bw_en ? {m_lum, m_lum, m_lum} : m_rgb));
    end
  end

endmodule

`default_nettype wire

//--- test/tb_gb_core_glue.sv
/*
  testbench for the glue top level with short hold and tap limits.
  inputs change 5 ns after the rising edge, the checker samples on the fall.
*/

`timescale 1ns/1ns
`default_nettype none

module tb_gb_core_glue;
  import gb_glue_pkg::*;

  logic        clk_sys = 1'b0;
  logic        pll_core_locked = 1'b0;
  logic        bridge_wr = 1'b0;
  logic [31:0] bridge_addr = '0;
  logic [31:0] bridge_wr_data = '0;
  logic        slot_request_write = 1'b0;
  logic [15:0] slot_id = '0;
  logic        slot_all_complete = 1'b0;
  logic        ioctl_wr = 1'b0;
  logic [15:0] ioctl_data = '0;
  logic        ff_button = 1'b0;
  logic [15:0] audio_in_l = '0;
  logic [15:0] audio_in_r = '0;
  logic        lcd_hblank = 1'b0;
  logic        lcd_vblank = 1'b0;
  logic        lcd_hs = 1'b0;
  logic        lcd_vs = 1'b0;
  logic [23:0] lcd_rgb = '0;
  logic        bw_en = 1'b0;

  wire [2:0]  mapper_sel;
  wire [1:0]  sys_type;
  wire [1:0]  tint;
  wire [1:0]  sgb_en;
  wire        rumble_en;
  wire        sgc_gbc_en;
  wire        rw_en;
  wire        core_reset;
  wire        cart_download;
  wire        border_download;
  wire        boot_download;
  wire [23:0] pal1;
  wire [23:0] pal2;
  wire [23:0] pal3;
  wire [23:0] pal4;
  wire        fast_forward;
  wire [15:0] audio_out_l;
  wire [15:0] audio_out_r;
  wire        video_de;
  wire        video_hs;
  wire        video_vs;
  wire [23:0] video_rgb;
  wire [31:0] chk_errors;

  logic [31:0] lfsr = 32'hac1cefc0;
  int          tb_errors = 0;
  int          tests_run = 0;
  int          test_start = 0;

  gb_core_glue #(
    .RESET_HOLD_CYCLES (16),
    .TAP_MAX_CYCLES    (20)
  ) dut0 (.*);

  glue_checker #(
    .RESET_HOLD_CYCLES (16),
    .TAP_MAX_CYCLES    (20)
  ) chk0 (.*, .error_count(chk_errors));

  initial begin
    forever #50 clk_sys = ~clk_sys;
  end

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  // next drive point, audio keeps moving every cycle
  task automatic next_cycle();
    logic [31:0] r;
    @(posedge clk_sys);
    #5;
    r = rand_bits(32);
    audio_in_l = r[15:0];
    audio_in_r = r[31:16];
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++) next_cycle();
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    bridge_addr = addr;
    bridge_wr_data = data;
    bridge_wr = 1'b1;
    next_cycle();
    bridge_wr = 1'b0;
  endtask

  task automatic wait_core_reset_low(input int limit);
    logic done;
    done = 1'b0;
    for (int i = 0; i < limit && !done; i++) begin
      if (!core_reset) done = 1'b1;
      else next_cycle();
    end
    if (!done) begin
      $display("timeout: core_reset stayed high for %0d cycles", limit);
      $display(">>> FAIL");
      $finish;
    end
  endtask

  task automatic start_download(input logic [15:0] id);
    slot_id = id;
    slot_request_write = 1'b1;
    next_cycle();
    slot_request_write = 1'b0;
  endtask

  task automatic finish_download();
    slot_all_complete = 1'b1;
    next_cycle();
    slot_all_complete = 1'b0;
  endtask

  task automatic press(input int n);
    ff_button = 1'b1;
    idle(n);
    ff_button = 1'b0;
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = int'(chk_errors) + tb_errors - test_start;
    tests_run++;
    $display("test %-10s %s (%0d errors)", name, errs == 0 ? "ok" : "failed", errs);
    test_start = int'(chk_errors) + tb_errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    logic [31:0] r;
    logic [31:0] addrs [10];
    int hold_len;
    int total;

    addrs = '{REG_RESET_ADDR, REG_MAPPER_ADDR, REG_RUMBLE_ADDR, REG_SYSTYPE_ADDR,
              REG_FFSND_ADDR, REG_TINT_ADDR, REG_SGB_ADDR, REG_SGBGBC_ADDR,
              REG_REWIND_ADDR, 32'h0000_0300};
    repeat (4) @(posedge clk_sys);
    #5;
    pll_core_locked = 1'b1;
    idle(2);

    // options, with the ffsnd write forced back to 0 at the end
    for (int i = 0; i < 40; i++) begin
      r = rand_bits(4);
      write_reg(addrs[r % 10], rand_bits(32));
    end
    write_reg(REG_FFSND_ADDR, 32'h0);
    wait_core_reset_low(40);
    write_reg(REG_RESET_ADDR, rand_bits(32));
    hold_len = 0;
    while (core_reset && hold_len < 40) begin
      hold_len++;
      next_cycle();
    end
    if (hold_len != 16) begin
      tb_errors++;
      $display("ERROR @%0t ns: core_reset held %0d cycles, expected 16", $time, hold_len);
    end
    end_test("options");

    // download classes
    for (int i = 0; i < 9; i++) begin
      case (i)
        0: start_download(16'd1);
        1: start_download(16'h80);
        2: start_download(16'h41);
        3: start_download(16'd3);
        4: start_download(16'd2);
        5: start_download(16'd4);
        6: start_download(16'd5);
        7: start_download(16'd6);
        default: start_download(16'd9);
      endcase
      idle(4);
      finish_download();
      wait_core_reset_low(10);
      idle(2);
    end
    end_test("download");

    // palette
    start_download(16'd3);
    for (int i = 0; i < 9; i++) begin
      r = rand_bits(16);
      ioctl_data = r[15:0];
      ioctl_wr = 1'b1;
      next_cycle();
      ioctl_wr = 1'b0;
      idle(1);
    end
    finish_download();
    for (int i = 0; i < 3; i++) begin
      r = rand_bits(16);
      ioctl_data = r[15:0];
      ioctl_wr = 1'b1;
      next_cycle();
    end
    ioctl_wr = 1'b0;
    idle(3);
    end_test("palette");

    // hold, tap, clearing press, tap that must not latch, press while loading
    press(40);
    idle(5);
    press(3);
    idle(10);
    press(3);
    idle(6);
    press(3);
    idle(6);
    start_download(16'd9);
    press(5);
    idle(3);
    finish_download();
    idle(4);
    // presses on either side of the tap limit
    press(20);
    idle(4);
    press(20);
    idle(4);
    press(19);
    idle(4);
    end_test("fastfwd");

    // audio muted, then passed with sound enabled
    press(10);
    idle(10);
    write_reg(REG_FFSND_ADDR, 32'h1);
    idle(10);
    press(3);
    idle(6);
    write_reg(REG_FFSND_ADDR, 32'h0);
    idle(4);
    end_test("audio");

    // random video stream
    for (int i = 0; i < 400; i++) begin
      lcd_hblank = rand_bits(3) == 0;
      lcd_vblank = rand_bits(4) == 0;
      if (rand_bits(3) == 0) lcd_hs = ~lcd_hs;
      if (rand_bits(4) == 0) lcd_vs = ~lcd_vs;
      r = rand_bits(24);
      lcd_rgb = r[23:0];
      if (rand_bits(5) == 0) bw_en = ~bw_en;
      next_cycle();
    end
    idle(10);
    end_test("video");

    total = int'(chk_errors) + tb_errors;
    $display("%0d tests run, %0d errors", tests_run, total);
    if (total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
